/* bank_router.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module bank_router (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  awvalid,
    input  logic [31:0]           awaddr,
    input  logic                  wvalid,
    input  logic                  arvalid,
    input  logic [31:0]           araddr,
    input  logic [`MEM_BANKS-1:0] bank_awready,
    input  logic [`MEM_BANKS-1:0] bank_wready,
    input  logic [`MEM_BANKS-1:0] bank_arready,
    input  logic                  bready,
    input  logic                  rready,
    output logic                  awready,
    output logic                  wready,
    output logic                  arready,
    output logic [`MEM_BANKS-1:0] bank_awvalid,
    output logic [`MEM_BANKS-1:0] bank_wvalid,
    output logic [`MEM_BANKS-1:0] bank_arvalid,
    output logic                  err_bvalid,
    output logic                  err_rvalid
);

    localparam int BANK_BITS = $clog2(`MEM_BANKS);
    localparam logic [`MEM_BANKS-1:0] BANK_ONE = 1;

    logic [31:0]          aw_off;
    logic [31:0]          ar_off;
    logic                 aw_hit;
    logic                 ar_hit;
    logic [BANK_BITS-1:0] aw_idx;
    logic [BANK_BITS-1:0] ar_idx;

    // Offsets wrap below the base, so one compare covers both bounds
    assign aw_off = awaddr - `MEM_BASE;
    assign ar_off = araddr - `MEM_BASE;
    assign aw_hit = (aw_off < `MEM_BYTES);
    assign ar_hit = (ar_off < `MEM_BYTES);
    assign aw_idx = awaddr[2 +: BANK_BITS];
    assign ar_idx = araddr[2 +: BANK_BITS];

    assign bank_awvalid = (awvalid && aw_hit) ? (BANK_ONE << aw_idx) : '0;
    assign bank_wvalid  = (wvalid && aw_hit) ? (BANK_ONE << aw_idx) : '0;
    assign bank_arvalid = (arvalid && ar_hit) ? (BANK_ONE << ar_idx) : '0;

    // Error slave takes aw and w together, like a bank
    assign awready = aw_hit ? bank_awready[aw_idx] : (wvalid && !err_bvalid);
    assign wready  = aw_hit ? bank_wready[aw_idx] : (awvalid && !err_bvalid);
    assign arready = ar_hit ? bank_arready[ar_idx] : !err_rvalid;

    // ##################################################
    // Decode error responses
    // ##################################################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            err_bvalid <= 1'b0;
            err_rvalid <= 1'b0;
        end else begin
            if (awvalid && wvalid && !aw_hit && !err_bvalid) err_bvalid <= 1'b1;
            else if (err_bvalid && bready) err_bvalid <= 1'b0;
            if (arvalid && !ar_hit && !err_rvalid) err_rvalid <= 1'b1;
            else if (err_rvalid && rready) err_rvalid <= 1'b0;
        end
    end

endmodule

/* files.f */
+incdir+.
mem_pkg.sv
lsu.sv
bank_router.sv
sram_bank.sv
resp_merge.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* lsu.sv */
`timescale 1ns/1ps

module lsu (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 exu_valid,
    input  logic                 wbu_ready,
    input  mem_pkg::mem_op_e     req_op,
    input  mem_pkg::mem_width_e  req_width,
    input  logic [31:0]          req_addr,
    input  logic [31:0]          req_wdata,
    output logic                 lsu_ready,
    output logic                 lsu_valid,
    output logic [31:0]          wb_addr,
    output logic [31:0]          wb_data,
    output logic                 access_fault,
    input  logic                 awready,
    output logic                 awvalid,
    output logic [31:0]          awaddr,
    input  logic                 wready,
    output logic                 wvalid,
    output logic [31:0]          wdata,
    output logic [3:0]           wstrb,
    input  logic                 bvalid,
    input  mem_pkg::resp_e       bresp,
    output logic                 bready,
    input  logic                 arready,
    output logic                 arvalid,
    output logic [31:0]          araddr,
    input  logic                 rvalid,
    input  mem_pkg::resp_e       rresp,
    input  logic [31:0]          rdata,
    output logic                 rready
);

    mem_pkg::lsu_state_e state_q;
    logic                take;
    logic                is_load;
    logic                is_store;
    logic [1:0]          offset;
    logic [31:0]         store_data;
    logic [3:0]          store_strb;

    assign lsu_ready = (state_q == mem_pkg::IDLE);
    assign take      = exu_valid && lsu_ready;
    assign is_load   = (req_op == mem_pkg::OP_LOAD);
    assign is_store  = (req_op == mem_pkg::OP_STORE);

    // Store data moved onto its byte lanes
    assign offset     = req_addr[1:0];
    assign store_data = req_wdata << {offset, 3'b000};

    always_comb begin
        case (req_width)
            mem_pkg::W_BYTE: store_strb = 4'b0001 << offset;
            mem_pkg::W_HALF: store_strb = 4'b0011 << offset;
            mem_pkg::W_WORD: store_strb = 4'b1111 << offset;
            default:         store_strb = 4'b0000;
        endcase
    end

    // ##################################################
    // Control FSM and channel valids
    // ##################################################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= mem_pkg::IDLE;
            lsu_valid    <= 1'b0;
            access_fault <= 1'b0;
            awvalid      <= 1'b0;
            wvalid       <= 1'b0;
            bready       <= 1'b0;
            arvalid      <= 1'b0;
            rready       <= 1'b0;
        end else begin
            case (state_q)
                mem_pkg::IDLE: begin
                    if (take) begin
                        state_q <= mem_pkg::BUSY;
                        if (is_load) begin
                            arvalid <= 1'b1;
                            rready  <= 1'b1;
                        end else if (is_store) begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            bready  <= 1'b1;
                        end else begin
                            // No memory access, result is ready next cycle
                            lsu_valid    <= 1'b1;
                            access_fault <= 1'b0;
                        end
                    end
                end
                mem_pkg::BUSY: begin
                    if (awvalid && awready) awvalid <= 1'b0;
                    if (wvalid && wready) wvalid <= 1'b0;
                    if (arvalid && arready) arvalid <= 1'b0;
                    if (bvalid && bready) begin
                        bready       <= 1'b0;
                        lsu_valid    <= 1'b1;
                        access_fault <= (bresp != mem_pkg::RESP_OKAY);
                    end
                    if (rvalid && rready) begin
                        rready       <= 1'b0;
                        lsu_valid    <= 1'b1;
                        access_fault <= (rresp != mem_pkg::RESP_OKAY);
                    end
                    // Result held until write-back takes it
                    if (lsu_valid && wbu_ready) begin
                        lsu_valid <= 1'b0;
                        state_q   <= mem_pkg::IDLE;
                    end
                end
                default: state_q <= mem_pkg::IDLE;
            endcase
        end
    end

    // Request and result payload
    always_ff @(posedge clk) begin
        if (take) begin
            wb_addr <= req_addr;
            awaddr  <= req_addr;
            araddr  <= req_addr;
            wdata   <= store_data;
            wstrb   <= store_strb;
            if (!is_load && !is_store) wb_data <= req_addr;
        end else if (bvalid && bready) begin
            wb_data <= 32'h0;
        end else if (rvalid && rready) begin
            wb_data <= rdata;
        end
    end

endmodule

/* mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// ##################################################
// Banked data memory geometry
// ##################################################

// Bank count, must stay a power of two
`define MEM_BANKS 4

// 32-bit words held by each bank
`define MEM_BANK_WORDS 256

// Start of the banked region
`define MEM_BASE 32'h8000_0000

// Region size in bytes
`define MEM_BYTES (`MEM_BANKS * `MEM_BANK_WORDS * 4)

`endif

/* mem_pkg.sv */
package mem_pkg;

    // Load/store unit states
    typedef enum logic [0:0] {
        IDLE,
        BUSY
    } lsu_state_e;

    // Memory operation from execute
    typedef enum logic [1:0] {
        OP_NONE,
        OP_LOAD,
        OP_STORE
    } mem_op_e;

    // Access width
    typedef enum logic [1:0] {
        W_BYTE,
        W_HALF,
        W_WORD
    } mem_width_e;

    // Response codes, AXI encoding
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

endpackage

/* mem_subsys_top.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_subsys_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                exu_valid,
    input  logic                wbu_ready,
    input  mem_pkg::mem_op_e    req_op,
    input  mem_pkg::mem_width_e req_width,
    input  logic [31:0]         req_addr,
    input  logic [31:0]         req_wdata,
    output logic                lsu_ready,
    output logic                lsu_valid,
    output logic [31:0]         wb_addr,
    output logic [31:0]         wb_data,
    output logic                access_fault
);

    localparam int NB = `MEM_BANKS;

    logic                awvalid, awready, wvalid, wready, bvalid, bready;
    logic                arvalid, arready, rvalid, rready;
    logic [31:0]         awaddr, wdata, araddr, rdata;
    logic [3:0]          wstrb;
    mem_pkg::resp_e      bresp, rresp;
    logic [NB-1:0]       bank_awvalid, bank_awready, bank_wvalid, bank_wready;
    logic [NB-1:0]       bank_arvalid, bank_arready, bank_bvalid, bank_rvalid;
    logic [2*NB-1:0]     bank_bresp, bank_rresp;
    logic [32*NB-1:0]    bank_rdata;
    logic                err_bvalid, err_rvalid;

    lsu u_lsu (.*);

    bank_router u_router (.*);

    // ##################################################
    // Interleaved banks
    // ##################################################
    for (genvar g = 0; g < NB; g++) begin : g_bank
        sram_bank u_bank (
            .clk     (clk),
            .rst     (rst),
            .awvalid (bank_awvalid[g]),
            .awaddr  (awaddr),
            .awready (bank_awready[g]),
            .wvalid  (bank_wvalid[g]),
            .wdata   (wdata),
            .wstrb   (wstrb),
            .wready  (bank_wready[g]),
            .bvalid  (bank_bvalid[g]),
            .bresp   (bank_bresp[2*g +: 2]),
            .bready  (bready),
            .arvalid (bank_arvalid[g]),
            .araddr  (araddr),
            .arready (bank_arready[g]),
            .rvalid  (bank_rvalid[g]),
            .rresp   (bank_rresp[2*g +: 2]),
            .rdata   (bank_rdata[32*g +: 32]),
            .rready  (rready)
        );
    end

    resp_merge u_merge (.*);

endmodule

/* resp_merge.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module resp_merge (
    input  logic [`MEM_BANKS-1:0]    bank_bvalid,
    input  logic [2*`MEM_BANKS-1:0]  bank_bresp,
    input  logic [`MEM_BANKS-1:0]    bank_rvalid,
    input  logic [2*`MEM_BANKS-1:0]  bank_rresp,
    input  logic [32*`MEM_BANKS-1:0] bank_rdata,
    input  logic                     err_bvalid,
    input  logic                     err_rvalid,
    output logic                     bvalid,
    output mem_pkg::resp_e           bresp,
    output logic                     rvalid,
    output mem_pkg::resp_e           rresp,
    output logic [31:0]              rdata
);

    logic [1:0]  b_code;
    logic [1:0]  r_code;
    logic [31:0] r_word;

    assign bvalid = (|bank_bvalid) || err_bvalid;
    assign rvalid = (|bank_rvalid) || err_rvalid;

    // AND-OR mux, at most one source is active
    always_comb begin
        b_code = 2'b00;
        r_code = 2'b00;
        r_word = 32'h0;
        for (int i = 0; i < `MEM_BANKS; i++) begin
            b_code = b_code | ({2{bank_bvalid[i]}} & bank_bresp[2*i +: 2]);
            r_code = r_code | ({2{bank_rvalid[i]}} & bank_rresp[2*i +: 2]);
            r_word = r_word | ({32{bank_rvalid[i]}} & bank_rdata[32*i +: 32]);
        end
        // Decode error carries no data
        if (err_bvalid) b_code = b_code | mem_pkg::RESP_DECERR;
        if (err_rvalid) r_code = r_code | mem_pkg::RESP_DECERR;
    end

    assign bresp = mem_pkg::resp_e'(b_code);
    assign rresp = mem_pkg::resp_e'(r_code);
    assign rdata = r_word;

endmodule

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_mem_subsys -f files.f -o tb_mem_subsys
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mem_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* sram_bank.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module sram_bank (
    input  logic           clk,
    input  logic           rst,
    input  logic           awvalid,
    input  logic [31:0]    awaddr,
    output logic           awready,
    input  logic           wvalid,
    input  logic [31:0]    wdata,
    input  logic [3:0]     wstrb,
    output logic           wready,
    output logic           bvalid,
    output mem_pkg::resp_e bresp,
    input  logic           bready,
    input  logic           arvalid,
    input  logic [31:0]    araddr,
    output logic           arready,
    output logic           rvalid,
    output mem_pkg::resp_e rresp,
    output logic [31:0]    rdata,
    input  logic           rready
);

    localparam int BANK_BITS = $clog2(`MEM_BANKS);
    localparam int WORD_BITS = $clog2(`MEM_BANK_WORDS);

    logic [31:0]          mem [`MEM_BANK_WORDS];
    logic [WORD_BITS-1:0] w_idx;
    logic [WORD_BITS-1:0] r_idx;
    logic                 w_take;
    logic                 r_take;

    // Word index sits above the bank select bits
    assign w_idx = awaddr[2 + BANK_BITS +: WORD_BITS];
    assign r_idx = araddr[2 + BANK_BITS +: WORD_BITS];

    // One response slot per direction
    assign awready = wvalid && !bvalid;
    assign wready  = awvalid && !bvalid;
    assign arready = !rvalid;
    assign w_take  = awvalid && wvalid && !bvalid;
    assign r_take  = arvalid && !rvalid;

    // Reads never fail inside a bank
    assign rresp = mem_pkg::RESP_OKAY;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (w_take) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (r_take) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

    // ##################################################
    // Storage array
    // ##################################################
    always_ff @(posedge clk) begin
        if (w_take) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) mem[w_idx][8*b +: 8] <= wdata[8*b +: 8];
            end
            // Empty strobe is rejected
            bresp <= (wstrb == 4'b0000) ? mem_pkg::RESP_SLVERR : mem_pkg::RESP_OKAY;
        end
        if (r_take) rdata <= mem[r_idx];
    end

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_mem_subsys;

    localparam int MAX_TESTS  = 40;
    localparam int TIMEOUT    = 100;
    localparam int MODEL_BITS = $clog2(`MEM_BYTES);

    localparam mem_pkg::mem_op_e    NOP  = mem_pkg::OP_NONE;
    localparam mem_pkg::mem_op_e    LD   = mem_pkg::OP_LOAD;
    localparam mem_pkg::mem_op_e    ST   = mem_pkg::OP_STORE;
    localparam mem_pkg::mem_width_e BYTE = mem_pkg::W_BYTE;
    localparam mem_pkg::mem_width_e HALF = mem_pkg::W_HALF;
    localparam mem_pkg::mem_width_e WORD = mem_pkg::W_WORD;

    logic                clk;
    logic                rst;
    logic                exu_valid;
    logic                wbu_ready;
    mem_pkg::mem_op_e    req_op;
    mem_pkg::mem_width_e req_width;
    logic [31:0]         req_addr;
    logic [31:0]         req_wdata;
    logic                lsu_ready;
    logic                lsu_valid;
    logic [31:0]         wb_addr;
    logic [31:0]         wb_data;
    logic                access_fault;

    // Stimulus table with one entry per test
    string               t_name  [MAX_TESTS];
    mem_pkg::mem_op_e    t_op    [MAX_TESTS];
    mem_pkg::mem_width_e t_width [MAX_TESTS];
    logic [31:0]         t_addr  [MAX_TESTS];
    logic [31:0]         t_wdata [MAX_TESTS];
    logic                t_hold  [MAX_TESTS];
    logic                t_fault [MAX_TESTS];
    int                  n_tests;

    logic [7:0]  model [`MEM_BYTES];
    logic [31:0] seed;
    int          pass_count;
    int          fail_count;
    logic        timed_out;

    mem_subsys_top dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_test(input string name, input mem_pkg::mem_op_e op,
                            input mem_pkg::mem_width_e width, input logic [31:0] addr,
                            input logic hold, input logic fault);
        seed              = xorshift32(seed);
        t_name[n_tests]   = name;
        t_op[n_tests]     = op;
        t_width[n_tests]  = width;
        t_addr[n_tests]   = addr;
        t_wdata[n_tests]  = seed;
        t_hold[n_tests]   = hold;
        t_fault[n_tests]  = fault;
        n_tests++;
    endtask

    // ##################################################
    // Reference byte model
    // ##################################################
    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [MODEL_BITS-1:0] idx;
        logic [31:0]           word;
        for (int k = 0; k < 4; k++) begin
            idx = MODEL_BITS'((addr & ~32'h3) - `MEM_BASE + k);
            word[8*k +: 8] = model[idx];
        end
        return word;
    endfunction

    // Byte k of the data goes to address plus k within the same word
    task automatic model_store(input logic [31:0] addr, input mem_pkg::mem_width_e width,
                               input logic [31:0] data);
        logic [MODEL_BITS-1:0] idx;
        int                    size;
        size = (width == BYTE) ? 1 : (width == HALF) ? 2 : 4;
        for (int k = 0; k < size; k++) begin
            if (int'(addr[1:0]) + k < 4) begin
                idx = MODEL_BITS'(addr - `MEM_BASE + k);
                model[idx] = data[8*k +: 8];
            end
        end
    endtask

    task automatic build_table();
        add_test("st_w_bank0", ST, WORD, `MEM_BASE + 32'h00, 1'b0, 1'b0);
        add_test("st_w_bank1", ST, WORD, `MEM_BASE + 32'h04, 1'b0, 1'b0);
        add_test("st_w_bank2", ST, WORD, `MEM_BASE + 32'h08, 1'b0, 1'b0);
        add_test("st_w_bank3", ST, WORD, `MEM_BASE + 32'h0C, 1'b0, 1'b0);
        add_test("ld_w_bank0", LD, WORD, `MEM_BASE + 32'h00, 1'b0, 1'b0);
        add_test("ld_w_bank1", LD, WORD, `MEM_BASE + 32'h04, 1'b0, 1'b0);
        add_test("ld_w_bank2", LD, WORD, `MEM_BASE + 32'h08, 1'b0, 1'b0);
        add_test("ld_w_bank3", LD, WORD, `MEM_BASE + 32'h0C, 1'b0, 1'b0);
        add_test("st_w_lanes", ST, WORD, `MEM_BASE + 32'h10, 1'b0, 1'b0);
        add_test("st_b_off0", ST, BYTE, `MEM_BASE + 32'h10, 1'b0, 1'b0);
        add_test("ld_b_off0", LD, WORD, `MEM_BASE + 32'h10, 1'b0, 1'b0);
        add_test("st_b_off1", ST, BYTE, `MEM_BASE + 32'h11, 1'b0, 1'b0);
        add_test("ld_b_off1", LD, WORD, `MEM_BASE + 32'h10, 1'b0, 1'b0);
        add_test("st_b_off2", ST, BYTE, `MEM_BASE + 32'h12, 1'b0, 1'b0);
        add_test("ld_b_off2", LD, WORD, `MEM_BASE + 32'h10, 1'b0, 1'b0);
        add_test("st_b_off3", ST, BYTE, `MEM_BASE + 32'h13, 1'b0, 1'b0);
        add_test("ld_b_off3", LD, WORD, `MEM_BASE + 32'h10, 1'b0, 1'b0);
        add_test("st_w_halves", ST, WORD, `MEM_BASE + 32'h24, 1'b0, 1'b0);
        add_test("st_h_off0", ST, HALF, `MEM_BASE + 32'h24, 1'b0, 1'b0);
        add_test("ld_h_off0", LD, WORD, `MEM_BASE + 32'h24, 1'b0, 1'b0);
        add_test("st_h_off1", ST, HALF, `MEM_BASE + 32'h25, 1'b0, 1'b0);
        add_test("ld_h_off1", LD, WORD, `MEM_BASE + 32'h24, 1'b0, 1'b0);
        add_test("st_h_off2", ST, HALF, `MEM_BASE + 32'h26, 1'b0, 1'b0);
        add_test("ld_h_off2", LD, WORD, `MEM_BASE + 32'h24, 1'b0, 1'b0);
        add_test("st_h_off3", ST, HALF, `MEM_BASE + 32'h27, 1'b0, 1'b0);
        add_test("ld_h_off3", LD, WORD, `MEM_BASE + 32'h24, 1'b0, 1'b0);
        add_test("nop_addr", NOP, WORD, 32'h1234_5678, 1'b0, 1'b0);
        add_test("st_w_top", ST, WORD, `MEM_BASE + `MEM_BYTES - 4, 1'b0, 1'b0);
        add_test("ld_oob_hi", LD, WORD, `MEM_BASE + `MEM_BYTES, 1'b0, 1'b1);
        add_test("st_oob_hi", ST, WORD, `MEM_BASE + `MEM_BYTES, 1'b0, 1'b1);
        add_test("st_oob_lo", ST, WORD, `MEM_BASE - 4, 1'b0, 1'b1);
        add_test("ld_top", LD, WORD, `MEM_BASE + `MEM_BYTES - 4, 1'b0, 1'b0);
        add_test("ld_base", LD, WORD, `MEM_BASE, 1'b0, 1'b0);
        add_test("ld_stall", LD, WORD, `MEM_BASE + 32'h04, 1'b1, 1'b0);
        add_test("st_stall", ST, WORD, `MEM_BASE + 32'h18, 1'b1, 1'b0);
        add_test("nop_stall", NOP, WORD, 32'h0000_0ABC, 1'b1, 1'b0);
        add_test("ld_after_stall", LD, WORD, `MEM_BASE + 32'h18, 1'b0, 1'b0);
    endtask

    // ##################################################
    // One table entry through the DUT
    // ##################################################
    task automatic run_test(input int i);
        logic [31:0] exp_data;
        logic [31:0] held_addr;
        logic [31:0] held_data;
        logic        held_fault;
        int          cycles;
        int          errors;
        errors = 0;
        cycles = 0;
        while (!lsu_ready && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!lsu_ready) begin
            $display("%s: unit never became ready, result never arrived", t_name[i]);
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);
        exu_valid <= 1'b1;
        req_op    <= t_op[i];
        req_width <= t_width[i];
        req_addr  <= t_addr[i];
        req_wdata <= t_wdata[i];
        wbu_ready <= !t_hold[i];
        // Request is taken on this edge and its fields stay put until acceptance
        @(posedge clk);
        exu_valid <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!lsu_valid && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!lsu_valid) begin
            $display("%s: result never arrived", t_name[i]);
            timed_out = 1'b1;
            return;
        end
        case (t_op[i])
            LD:      exp_data = t_fault[i] ? 32'h0 : model_word(t_addr[i]);
            ST:      exp_data = 32'h0;
            default: exp_data = t_addr[i];
        endcase
        if (wb_addr !== t_addr[i]) begin
            $display("Mismatch %s wb_addr expected %h actual %h", t_name[i], t_addr[i], wb_addr);
            errors++;
        end
        if (wb_data !== exp_data) begin
            $display("Mismatch %s wb_data expected %h actual %h", t_name[i], exp_data, wb_data);
            errors++;
        end
        if (access_fault !== t_fault[i]) begin
            $display("Mismatch %s access_fault expected %b actual %b",
                     t_name[i], t_fault[i], access_fault);
            errors++;
        end
        if (t_hold[i]) begin
            held_addr  = wb_addr;
            held_data  = wb_data;
            held_fault = access_fault;
            repeat (4) begin
                @(negedge clk);
                if (!lsu_valid || lsu_ready) begin
                    $display("%s: handshake moved while write-back was stalled", t_name[i]);
                    errors++;
                end
                if (wb_addr !== held_addr || wb_data !== held_data
                        || access_fault !== held_fault) begin
                    $display("%s: result changed while write-back was stalled", t_name[i]);
                    errors++;
                end
            end
            @(posedge clk);
            wbu_ready <= 1'b1;
        end
        if (errors == 0) begin
            pass_count++;
            if (t_op[i] == ST && !t_fault[i]) model_store(t_addr[i], t_width[i], t_wdata[i]);
            $display("%-16s ok", t_name[i]);
        end else begin
            fail_count++;
            $display("%-16s FAILED", t_name[i]);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        exu_valid  = 1'b0;
        wbu_ready  = 1'b1;
        req_op     = NOP;
        req_width  = WORD;
        req_addr   = 32'h0;
        req_wdata  = 32'h0;
        seed       = 32'h26218097;
        n_tests    = 0;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        build_table();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < n_tests && !timed_out; i++) begin
            run_test(i);
        end
        $display("Passed %0d, failed %0d, of %0d entries", pass_count, fail_count, n_tests);
        if (timed_out || fail_count != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule
